//--- common/ptp_pkg.sv
`default_nettype none

package ptp_pkg;

    // timestamp layout: seconds in [95:48], ns in [45:16], fractional ns in [15:0]
    localparam int ts_w  = 96;
    localparam int sec_w = 48;
    localparam int ns_w  = 30;
    localparam int fns_w = 16;

    localparam logic [ns_w-1:0] ns_per_sec = 30'd1_000_000_000;

    // advance per clock, matches a 100 MHz clock
    localparam logic [ns_w-1:0]  inc_ns  = 30'd10;
    localparam logic [fns_w-1:0] inc_fns = 16'd0;

    localparam int wb_addr_w = 6;
    localparam int wb_data_w = 32;

    // global register map (word addresses)
    localparam logic [wb_addr_w-1:0] reg_ctrl    = 6'd0;
    localparam logic [wb_addr_w-1:0] reg_status  = 6'd1;
    localparam logic [wb_addr_w-1:0] reg_set_ns  = 6'd2;
    localparam logic [wb_addr_w-1:0] reg_set_s   = 6'd3;
    localparam logic [wb_addr_w-1:0] reg_time_ns = 6'd4;
    localparam logic [wb_addr_w-1:0] reg_time_s  = 6'd5;

    // channel windows, aligned to 8 words
    localparam logic [wb_addr_w-1:0] ch0_base = 6'd8;
    localparam logic [wb_addr_w-1:0] ch1_base = 6'd16;
    localparam int                   ch_words = 6;

    // offsets inside a channel window, the odd word commits the pair
    localparam logic [2:0] ch_start_ns  = 3'd0;
    localparam logic [2:0] ch_start_s   = 3'd1;
    localparam logic [2:0] ch_period_ns = 3'd2;
    localparam logic [2:0] ch_period_s  = 3'd3;
    localparam logic [2:0] ch_width_ns  = 3'd4;
    localparam logic [2:0] ch_width_s   = 3'd5;

    localparam logic [ts_w-1:0] def_start  = '0;
    localparam logic [ts_w-1:0] def_period = {48'd1, 2'b00, 30'd0, 16'd0};
    localparam logic [ts_w-1:0] def_width  = {48'd0, 2'b00, 30'd1000, 16'd0};

endpackage

`default_nettype wire

//--- ptp_clock/ptp_clock.sv
`timescale 1ns/1ps
`default_nettype none

module ptp_clock import ptp_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    input  wire [ts_w-1:0]   set_ts,
    input  wire              ts_step,
    output logic [ts_w-1:0]  ts
);

    logic [sec_w-1:0]        sec_q;
    // ns and fractional ns kept as one field so a single adder covers both
    logic [ns_w+fns_w-1:0]   nf_q;
    logic [ns_w+fns_w:0]     sum_nf;
    logic [ns_w+fns_w:0]     ovf_nf;

    assign sum_nf = {1'b0, nf_q} + {1'b0, inc_ns, inc_fns};

    // lookahead: no borrow here means the second has rolled over
    assign ovf_nf = sum_nf - {1'b0, ns_per_sec, {fns_w{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            sec_q <= '0;
            nf_q  <= '0;
        end else if (ts_step) begin
            // software step wins over counting
            sec_q <= set_ts[ts_w-1 -: sec_w];
            nf_q  <= set_ts[ns_w+fns_w-1:0];
        end else if (!ovf_nf[ns_w+fns_w]) begin
            sec_q <= sec_q + 1'b1;
            nf_q  <= ovf_nf[ns_w+fns_w-1:0];
        end else begin
            nf_q  <= sum_nf[ns_w+fns_w-1:0];
        end
    end

    // bits 47:46 are unused and read as zero
    assign ts = {sec_q, {(ts_w-sec_w-ns_w-fns_w){1'b0}}, nf_q};

endmodule

`default_nettype wire

//--- perout/ptp_perout.sv
`timescale 1ns/1ps
`default_nettype none

module ptp_perout import ptp_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire [ts_w-1:0]  ts,
    input  wire             ts_step,
    input  wire             enable,
    input  wire [ts_w-1:0]  start,
    input  wire             start_valid,
    input  wire [ts_w-1:0]  period,
    input  wire             period_valid,
    input  wire [ts_w-1:0]  width,
    input  wire             width_valid,
    output logic            locked,
    output logic            error,
    output logic            pulse
);

    localparam int nf_w = ns_w + fns_w;

    typedef enum logic [2:0] {
        st_idle,
        st_rise_1,
        st_rise_2,
        st_fall_1,
        st_fall_2,
        st_wait
    } state_t;

    state_t state;

    logic [sec_w-1:0] time_s;
    logic [nf_w-1:0]  time_nf;

    logic [sec_w-1:0] rise_s;
    logic [nf_w-1:0]  rise_nf;
    logic [sec_w-1:0] fall_s;
    logic [nf_w-1:0]  fall_nf;

    logic [ts_w-1:0]  start_q;
    logic [ts_w-1:0]  period_q;
    logic [ts_w-1:0]  width_q;

    logic [nf_w-1:0]  addend;
    logic [nf_w:0]    sum_c;
    logic [nf_w-1:0]  sum_nf;
    logic [nf_w:0]    ovf_nf;
    logic             carry;
    logic             level;
    logic             rise_hit;
    logic             fall_hit;

    // one adder serves both updates and every edge time is based on the rise time
    assign addend = (state == st_rise_1) ? period_q[nf_w-1:0] : width_q[nf_w-1:0];
    assign sum_c  = {1'b0, rise_nf} + {1'b0, addend};

    // no borrow in the second lookahead stage means an extra second
    assign carry = !ovf_nf[nf_w];

    assign rise_hit = (time_s > rise_s) || (time_s == rise_s && time_nf > rise_nf);
    assign fall_hit = (time_s > fall_s) || (time_s == fall_s && time_nf > fall_nf);

    // registered copy of the time costs one cycle on every edge alike
    always_ff @(posedge clk) begin
        time_s  <= ts[ts_w-1 -: sec_w];
        time_nf <= ts[nf_w-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            start_q  <= def_start;
            period_q <= def_period;
            width_q  <= def_width;
            locked   <= 1'b0;
            error    <= 1'b0;
            level    <= 1'b0;
            pulse    <= 1'b0;
        end else begin
            if (start_valid) begin
                start_q <= start;
            end
            if (period_valid) begin
                period_q <= period;
            end
            if (width_valid) begin
                width_q <= width;
            end

            if (start_valid || period_valid || ts_step) begin
                // schedule is no longer valid so start over from the start time
                locked <= 1'b0;
                level  <= 1'b0;
                pulse  <= 1'b0;
                error  <= error || ts_step;
                state  <= st_idle;
            end else begin
                case (state)
                    st_idle: begin
                        rise_s  <= start_q[ts_w-1 -: sec_w];
                        rise_nf <= start_q[nf_w-1:0];
                        locked  <= 1'b0;
                        level   <= 1'b0;
                        pulse   <= 1'b0;
                        state   <= st_fall_1;
                    end
                    st_rise_1, st_fall_1: begin
                        sum_nf <= sum_c[nf_w-1:0];
                        ovf_nf <= sum_c - {1'b0, ns_per_sec, {fns_w{1'b0}}};
                        state  <= (state == st_rise_1) ? st_rise_2 : st_fall_2;
                    end
                    st_rise_2: begin
                        rise_s  <= rise_s + period_q[ts_w-1 -: sec_w] + carry;
                        rise_nf <= carry ? ovf_nf[nf_w-1:0] : sum_nf;
                        state   <= st_wait;
                    end
                    st_fall_2: begin
                        fall_s  <= rise_s + width_q[ts_w-1 -: sec_w] + carry;
                        fall_nf <= carry ? ovf_nf[nf_w-1:0] : sum_nf;
                        state   <= st_wait;
                    end
                    st_wait: begin
                        if (rise_hit) begin
                            level <= 1'b1;
                            pulse <= enable && locked;
                            state <= st_rise_1;
                        end else if (fall_hit) begin
                            level <= 1'b0;
                            pulse <= 1'b0;
                            state <= st_fall_1;
                        end else begin
                            // caught up with time once the level has been high
                            locked <= locked || level;
                            error  <= error && !(locked || level);
                        end
                    end
                    default: begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/ptp_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ptp_regs import ptp_pkg::*; (
    input  wire                    clk,
    input  wire                    rst,
    input  wire [wb_addr_w-1:0]    adr,
    input  wire [wb_data_w-1:0]    dat_w,
    input  wire                    we,
    input  wire [wb_data_w/8-1:0]  sel,
    input  wire                    cyc,
    input  wire                    stb,
    input  wire [ts_w-1:0]         ts,
    input  wire [1:0]              locked,
    input  wire [1:0]              error,
    input  wire [1:0]              pulse,
    output logic [wb_data_w-1:0]   dat_r,
    output logic                   ack,
    output logic [ts_w-1:0]        set_ts,
    output logic                   ts_step,
    output logic [1:0]             enable,
    output logic [ts_w-1:0]        start0,
    output logic                   start_valid0,
    output logic [ts_w-1:0]        period0,
    output logic                   period_valid0,
    output logic [ts_w-1:0]        width0,
    output logic                   width_valid0,
    output logic [ts_w-1:0]        start1,
    output logic                   start_valid1,
    output logic [ts_w-1:0]        period1,
    output logic                   period_valid1,
    output logic [ts_w-1:0]        width1,
    output logic                   width_valid1
);

    logic [wb_data_w-1:0] set_ns_w;
    logic [wb_data_w-1:0] set_s_w;
    logic [wb_data_w-1:0] ch_reg [2][ch_words];
    logic [ts_w-1:0]      start_q [2];
    logic [ts_w-1:0]      period_q [2];
    logic [ts_w-1:0]      width_q [2];
    logic [1:0]           start_v;
    logic [1:0]           period_v;
    logic [1:0]           width_v;

    logic                 req;
    logic                 wr;
    logic [2:0]           ch_off;
    logic                 ch_hit0;
    logic                 ch_hit1;
    logic                 ch_sel;
    logic [wb_data_w-1:0] rd_mux;
    logic [wb_data_w-1:0] wr_word;

    // byte lane merge of the write data into the current word
    function automatic logic [wb_data_w-1:0] merge_word(input logic [wb_data_w-1:0] old_w,
                                                        input logic [wb_data_w-1:0] new_w,
                                                        input logic [wb_data_w/8-1:0] be);
        logic [wb_data_w-1:0] res;
        res = old_w;
        for (int i = 0; i < wb_data_w/8; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    // fractional ns are not programmable and stay zero
    function automatic logic [ts_w-1:0] mk_ts(input logic [wb_data_w-1:0] s_word,
                                              input logic [wb_data_w-1:0] ns_word);
        return {{(sec_w-wb_data_w){1'b0}}, s_word, {(ts_w-sec_w-ns_w-fns_w){1'b0}},
                ns_word[ns_w-1:0], {fns_w{1'b0}}};
    endfunction

    assign req     = cyc && stb;
    assign wr      = ack && req && we;
    assign ch_off  = adr[2:0];
    assign ch_hit0 = (adr[wb_addr_w-1:3] == ch0_base[wb_addr_w-1:3]) && (ch_off < ch_words);
    assign ch_hit1 = (adr[wb_addr_w-1:3] == ch1_base[wb_addr_w-1:3]) && (ch_off < ch_words);
    assign ch_sel  = ch_hit1;

    always_comb begin
        rd_mux = '0;
        if (ch_hit0 || ch_hit1) begin
            rd_mux = ch_reg[ch_sel][ch_off];
        end else begin
            case (adr)
                reg_ctrl:    rd_mux = {{(wb_data_w-2){1'b0}}, enable};
                reg_status:  rd_mux = {{(wb_data_w-7){1'b0}}, |error, pulse[1], pulse[0],
                                       error[1], locked[1], error[0], locked[0]};
                reg_set_ns:  rd_mux = set_ns_w;
                reg_set_s:   rd_mux = set_s_w;
                reg_time_ns: rd_mux = {{(wb_data_w-ns_w){1'b0}}, ts[fns_w +: ns_w]};
                reg_time_s:  rd_mux = ts[ts_w-sec_w +: wb_data_w];
                default:     rd_mux = '0;
            endcase
        end
    end

    assign wr_word = merge_word(rd_mux, dat_w, sel);

    // read data is captured with the request, so time reads see ts at that edge
    always_ff @(posedge clk) begin
        if (req && !ack) begin
            dat_r <= rd_mux;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack      <= 1'b0;
            ts_step  <= 1'b0;
            enable   <= 2'b00;
            start_v  <= 2'b00;
            period_v <= 2'b00;
            width_v  <= 2'b00;
            set_ns_w <= '0;
            set_s_w  <= '0;
            for (int c = 0; c < 2; c++) begin
                start_q[c]  <= def_start;
                period_q[c] <= def_period;
                width_q[c]  <= def_width;
                ch_reg[c][ch_start_ns]  <= {2'b00, def_start[fns_w +: ns_w]};
                ch_reg[c][ch_start_s]   <= def_start[ts_w-sec_w +: wb_data_w];
                ch_reg[c][ch_period_ns] <= {2'b00, def_period[fns_w +: ns_w]};
                ch_reg[c][ch_period_s]  <= def_period[ts_w-sec_w +: wb_data_w];
                ch_reg[c][ch_width_ns]  <= {2'b00, def_width[fns_w +: ns_w]};
                ch_reg[c][ch_width_s]   <= def_width[ts_w-sec_w +: wb_data_w];
            end
        end else begin
            ack      <= req && !ack;
            ts_step  <= 1'b0;
            start_v  <= 2'b00;
            period_v <= 2'b00;
            width_v  <= 2'b00;
            if (wr) begin
                case (adr)
                    reg_ctrl:   enable <= wr_word[1:0];
                    reg_set_ns: set_ns_w <= wr_word;
                    reg_set_s: begin
                        set_s_w <= wr_word;
                        set_ts  <= mk_ts(wr_word, set_ns_w);
                        ts_step <= 1'b1;
                    end
                    default: ;
                endcase
                if (ch_hit0 || ch_hit1) begin
                    ch_reg[ch_sel][ch_off] <= wr_word;
                    // the seconds word commits the pair with its ns word
                    case (ch_off)
                        ch_start_s: begin
                            start_q[ch_sel] <= mk_ts(wr_word, ch_reg[ch_sel][ch_start_ns]);
                            start_v[ch_sel] <= 1'b1;
                        end
                        ch_period_s: begin
                            period_q[ch_sel] <= mk_ts(wr_word, ch_reg[ch_sel][ch_period_ns]);
                            period_v[ch_sel] <= 1'b1;
                        end
                        ch_width_s: begin
                            width_q[ch_sel] <= mk_ts(wr_word, ch_reg[ch_sel][ch_width_ns]);
                            width_v[ch_sel] <= 1'b1;
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    assign start0        = start_q[0];
    assign start_valid0  = start_v[0];
    assign period0       = period_q[0];
    assign period_valid0 = period_v[0];
    assign width0        = width_q[0];
    assign width_valid0  = width_v[0];
    assign start1        = start_q[1];
    assign start_valid1  = start_v[1];
    assign period1       = period_q[1];
    assign period_valid1 = period_v[1];
    assign width1        = width_q[1];
    assign width_valid1  = width_v[1];

endmodule

`default_nettype wire

//--- logic/ptp_perout_top.sv
`timescale 1ns/1ps
`default_nettype none

module ptp_perout_top import ptp_pkg::*; (
    input  wire                    clk,
    input  wire                    rst,
    input  wire [wb_addr_w-1:0]    adr,
    input  wire [wb_data_w-1:0]    dat_w,
    output wire [wb_data_w-1:0]    dat_r,
    input  wire                    we,
    input  wire [wb_data_w/8-1:0]  sel,
    input  wire                    cyc,
    input  wire                    stb,
    output wire                    ack,
    output wire [1:0]              pulse,
    output wire [ts_w-1:0]         ts
);

    wire [ts_w-1:0] set_ts;
    wire            ts_step;
    wire [1:0]      enable;
    wire [1:0]      locked;
    wire [1:0]      error;

    wire [ts_w-1:0] start0;
    wire [ts_w-1:0] period0;
    wire [ts_w-1:0] width0;
    wire            start_valid0;
    wire            period_valid0;
    wire            width_valid0;
    wire [ts_w-1:0] start1;
    wire [ts_w-1:0] period1;
    wire [ts_w-1:0] width1;
    wire            start_valid1;
    wire            period_valid1;
    wire            width_valid1;

    ptp_clock clock_i (
        .clk     (clk),
        .rst     (rst),
        .set_ts  (set_ts),
        .ts_step (ts_step),
        .ts      (ts)
    );

    ptp_perout perout0_i (
        .clk          (clk),
        .rst          (rst),
        .ts           (ts),
        .ts_step      (ts_step),
        .enable       (enable[0]),
        .start        (start0),
        .start_valid  (start_valid0),
        .period       (period0),
        .period_valid (period_valid0),
        .width        (width0),
        .width_valid  (width_valid0),
        .locked       (locked[0]),
        .error        (error[0]),
        .pulse        (pulse[0])
    );

    ptp_perout perout1_i (
        .clk          (clk),
        .rst          (rst),
        .ts           (ts),
        .ts_step      (ts_step),
        .enable       (enable[1]),
        .start        (start1),
        .start_valid  (start_valid1),
        .period       (period1),
        .period_valid (period_valid1),
        .width        (width1),
        .width_valid  (width_valid1),
        .locked       (locked[1]),
        .error        (error[1]),
        .pulse        (pulse[1])
    );

    ptp_regs regs_i (
        .clk           (clk),
        .rst           (rst),
        .adr           (adr),
        .dat_w         (dat_w),
        .we            (we),
        .sel           (sel),
        .cyc           (cyc),
        .stb           (stb),
        .ts            (ts),
        .locked        (locked),
        .error         (error),
        .pulse         (pulse),
        .dat_r         (dat_r),
        .ack           (ack),
        .set_ts        (set_ts),
        .ts_step       (ts_step),
        .enable        (enable),
        .start0        (start0),
        .start_valid0  (start_valid0),
        .period0       (period0),
        .period_valid0 (period_valid0),
        .width0        (width0),
        .width_valid0  (width_valid0),
        .start1        (start1),
        .start_valid1  (start_valid1),
        .period1       (period1),
        .period_valid1 (period_valid1),
        .width1        (width1),
        .width_valid1  (width_valid1)
    );

endmodule

`default_nettype wire

//--- tb/tb_wb_tasks.svh
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
endfunction

// one new LFSR bit per data bit
task automatic rand_word(output logic [wb_data_w-1:0] w);
    for (int i = 0; i < wb_data_w; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        w[i] = lfsr_state[0];
    end
endtask

// called 1 ns after a rising edge, returns 1 ns after a rising edge
task automatic bus_cycle(input logic [wb_addr_w-1:0] a, input logic [wb_data_w-1:0] d,
                         input logic w, output logic [wb_data_w-1:0] q);
    int n;
    n     = 0;
    q     = '0;
    adr   = a;
    dat_w = d;
    we    = w;
    sel   = '1;
    cyc   = 1'b1;
    stb   = 1'b1;
    @(posedge clk);
    #1;
    while (!ack && n < ack_timeout) begin
        @(posedge clk);
        #1;
        n++;
    end
    if (ack) begin
        q = dat_r;
    end else begin
        $display("timeout: no ack on the bus for address %0d", a);
        errors++;
    end
    // request stays up through the ack cycle, the write is taken there
    @(posedge clk);
    #1;
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
endtask

task automatic write_reg(input logic [wb_addr_w-1:0] a, input logic [wb_data_w-1:0] d);
    logic [wb_data_w-1:0] unused;
    bus_cycle(a, d, 1'b1, unused);
endtask

task automatic read_reg(input logic [wb_addr_w-1:0] a, output logic [wb_data_w-1:0] q);
    bus_cycle(a, '0, 1'b0, q);
endtask

`endif

//--- tb/tb_ptp_perout_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ptp_perout_top import ptp_pkg::*; ();

    localparam int clk_ns       = 10;
    localparam int ack_timeout  = 16;
    localparam int edge_timeout = 2000;
    localparam int poll_limit   = 1000;

    logic                   clk;
    logic                   rst;
    logic [wb_addr_w-1:0]   adr;
    logic [wb_data_w-1:0]   dat_w;
    logic                   we;
    logic [wb_data_w/8-1:0] sel;
    logic                   cyc;
    logic                   stb;
    wire  [wb_data_w-1:0]   dat_r;
    wire                    ack;
    wire  [1:0]             pulse;
    wire  [ts_w-1:0]        ts;

    int          errors;
    int          checks;
    logic [15:0] lfsr_state;

    `include "tb_wb_tasks.svh"

    ptp_perout_top dut_i (
        .clk   (clk),
        .rst   (rst),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .we    (we),
        .sel   (sel),
        .cyc   (cyc),
        .stb   (stb),
        .ack   (ack),
        .pulse (pulse),
        .ts    (ts)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reference time model: add whole ns, wrap at one second
    function automatic logic [ts_w-1:0] add_ns(input logic [ts_w-1:0] t, input longint unsigned d);
        longint unsigned s;
        longint unsigned ns;
        s  = {16'd0, t[ts_w-1 -: sec_w]};
        ns = {34'd0, t[fns_w +: ns_w]} + d;
        s  = s + ns / {34'd0, ns_per_sec};
        ns = ns % {34'd0, ns_per_sec};
        return {s[sec_w-1:0], 2'b00, ns[ns_w-1:0], t[fns_w-1:0]};
    endfunction

    task automatic check_value(input string name, input logic [ts_w-1:0] got,
                               input logic [ts_w-1:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error: %0d ns %s expected 0x%0h got 0x%0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic end_test(input int num, input string name, input int err_mark);
        if (errors == err_mark) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - err_mark);
        end
    endtask

    task automatic wait_ts(input logic [ts_w-1:0] target);
        int n;
        n = 0;
        while (ts !== target && n < edge_timeout) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (ts !== target) begin
            $display("timeout: ts never took the stepped value");
            errors++;
        end
    endtask

    task automatic wait_pulse(input int ch, input logic lvl, output int cycles);
        cycles = 0;
        while (pulse[ch] !== lvl && cycles < edge_timeout) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (pulse[ch] !== lvl) begin
            $display("timeout: pulse[%0d] never went to %0d", ch, lvl);
            errors++;
        end
    endtask

    task automatic measure_channel(input int ch, output int high, output int period);
        int skip;
        int low;
        // sync to a low level so the next edge seen is a rising one
        wait_pulse(ch, 1'b0, skip);
        wait_pulse(ch, 1'b1, skip);
        wait_pulse(ch, 1'b0, high);
        wait_pulse(ch, 1'b1, low);
        period = high + low;
    endtask

    task automatic poll_status(input logic [wb_data_w-1:0] mask, input logic [wb_data_w-1:0] want,
                               output logic [wb_data_w-1:0] q);
        int n;
        n = 0;
        read_reg(reg_status, q);
        while ((q & mask) != want && n < poll_limit) begin
            read_reg(reg_status, q);
            n++;
        end
        if ((q & mask) != want) begin
            $display("timeout: status never showed 0x%0h under mask 0x%0h", want, mask);
            errors++;
        end
    endtask

    task automatic program_start(input logic [wb_addr_w-1:0] base, input logic [ts_w-1:0] t);
        write_reg(base + 6'(ch_start_ns), {2'b00, t[fns_w +: ns_w]});
        write_reg(base + 6'(ch_start_s), t[ts_w-sec_w +: wb_data_w]);
    endtask

    // width goes first, the later start commit restarts the schedule with all values
    task automatic program_channel(input logic [wb_addr_w-1:0] base, input logic [ts_w-1:0] t,
                                   input logic [wb_data_w-1:0] per_ns,
                                   input logic [wb_data_w-1:0] wid_ns);
        write_reg(base + 6'(ch_width_ns), wid_ns);
        write_reg(base + 6'(ch_width_s), 32'd0);
        write_reg(base + 6'(ch_period_ns), per_ns);
        write_reg(base + 6'(ch_period_s), 32'd0);
        program_start(base, t);
    endtask

    initial begin
        logic [ts_w-1:0]      t0;
        logic [ts_w-1:0]      set_val;
        logic [wb_data_w-1:0] q;
        logic [wb_data_w-1:0] w;
        logic [wb_data_w-1:0] expect_w [12];
        logic [wb_addr_w-1:0] a;
        int                   err_mark;
        int                   high;
        int                   period;
        int                   seen_high;

        rst        = 1'b1;
        adr        = '0;
        dat_w      = '0;
        we         = 1'b0;
        sel        = '0;
        cyc        = 1'b0;
        stb        = 1'b0;
        errors     = 0;
        checks     = 0;
        lfsr_state = 16'd53406;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        err_mark = errors;
        read_reg(reg_status, q);
        check_value("status", q, 0);
        check_value("pulse", pulse, 0);
        t0 = ts;
        @(posedge clk);
        #1;
        check_value("ts", ts, add_ns(t0, inc_ns));
        end_test(1, "reset state and clock increment", err_mark);

        err_mark = errors;
        for (int i = 0; i < 12; i++) begin
            a = (i < 6) ? ch0_base + 6'(i) : ch1_base + 6'(i - 6);
            rand_word(expect_w[i]);
            write_reg(a, expect_w[i]);
        end
        for (int i = 0; i < 12; i++) begin
            a = (i < 6) ? ch0_base + 6'(i) : ch1_base + 6'(i - 6);
            read_reg(a, q);
            check_value("dat_r", q, expect_w[i]);
        end
        rand_word(w);
        write_reg(reg_ctrl, w);
        read_reg(reg_ctrl, q);
        check_value("ctrl", q, {30'd0, w[1:0]});
        write_reg(reg_ctrl, 32'd0);
        end_test(2, "register readback", err_mark);

        err_mark = errors;
        set_val = {48'd5, 2'b00, 30'd999_999_950, 16'd0};
        write_reg(reg_set_ns, 32'd999_999_950);
        write_reg(reg_set_s, 32'd5);
        wait_ts(set_val);
        repeat (10) begin
            @(posedge clk);
            #1;
        end
        check_value("ts", ts, add_ns(set_val, 10 * inc_ns));
        check_value("ts seconds", ts[ts_w-1 -: sec_w], 6);
        read_reg(reg_time_s, q);
        check_value("time_s", q, 6);
        end_test(3, "clock step across a second", err_mark);

        err_mark = errors;
        set_val = add_ns(ts, 5000);
        program_channel(ch0_base, set_val, 400, 120);
        program_channel(ch1_base, set_val, 250, 50);
        write_reg(reg_ctrl, 32'd3);
        poll_status(32'h05, 32'h05, q);
        measure_channel(0, high, period);
        check_value("pulse[0] high cycles", high, 120 / clk_ns);
        check_value("pulse[0] period cycles", period, 400 / clk_ns);
        end_test(4, "channel 0 period and width", err_mark);

        err_mark = errors;
        measure_channel(1, high, period);
        check_value("pulse[1] high cycles", high, 50 / clk_ns);
        check_value("pulse[1] period cycles", period, 250 / clk_ns);
        write_reg(reg_ctrl, 32'd1);
        // a pulse already high still runs out its width
        repeat (8) begin
            @(posedge clk);
            #1;
        end
        seen_high = 0;
        repeat (60) begin
            @(posedge clk);
            #1;
            seen_high = seen_high + int'(pulse[1]);
        end
        check_value("pulse[1] high cycles while disabled", seen_high, 0);
        read_reg(reg_status, q);
        check_value("status locked1", q[2], 1);
        end_test(5, "channel 1 timing and enable", err_mark);

        err_mark = errors;
        write_reg(reg_set_ns, 32'd0);
        write_reg(reg_set_s, 32'd10);
        poll_status(32'h0a, 32'h0a, q);
        check_value("status locked0", q[0], 0);
        check_value("status locked1", q[2], 0);
        check_value("status any error", q[6], 1);
        set_val = add_ns(ts, 5000);
        program_start(ch0_base, set_val);
        program_start(ch1_base, set_val);
        poll_status(32'h05, 32'h05, q);
        check_value("status error0", q[1], 0);
        check_value("status error1", q[3], 0);
        check_value("status any error", q[6], 0);
        end_test(6, "step error and relock", err_mark);

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+tb
common/ptp_pkg.sv
ptp_clock/ptp_clock.sv
perout/ptp_perout.sv
logic/ptp_regs.sv
logic/ptp_perout_top.sv
tb/tb_ptp_perout_top.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_ptp_perout_top || { echo "build failed"; exit 1; }
out="$(./obj_dir/Vtb_ptp_perout_top)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "^TEST PASSED$" && echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
